//--- common/rv_pkg.sv
`default_nettype none

package rv_pkg;

  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;

  typedef logic [XLEN-1:0]       word_t;
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;

  localparam word_t RESET_PC = 32'h0000_0000;

  // major opcodes, inst[6:0]
  localparam logic [6:0] OP_LUI      = 7'b0110111;
  localparam logic [6:0] OP_AUIPC    = 7'b0010111;
  localparam logic [6:0] OP_JAL      = 7'b1101111;
  localparam logic [6:0] OP_JALR     = 7'b1100111;
  localparam logic [6:0] OP_BRANCH   = 7'b1100011;
  localparam logic [6:0] OP_REG_IMM  = 7'b0010011;
  localparam logic [6:0] OP_REG_REG  = 7'b0110011;
  localparam logic [6:0] OP_MISC_MEM = 7'b0001111;
  localparam logic [6:0] OP_SYSTEM   = 7'b1110011;

  typedef struct packed {
    logic [6:0] funct7;
    reg_addr_t  rs2;
    reg_addr_t  rs1;
    logic [2:0] funct3;
    reg_addr_t  rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm_11_0;
    reg_addr_t   rs1;
    logic [2:0]  funct3;
    reg_addr_t   rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  // branch offset bits are scattered around rs1/rs2
  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    reg_addr_t  rs2;
    reg_addr_t  rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm_31_12;
    reg_addr_t   rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    reg_addr_t  rd;
    logic [6:0] opcode;
  } j_fmt_t;

  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    b_fmt_t b;
    u_fmt_t u;
    j_fmt_t j;
  } insn_t;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
    ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
  } alu_op_e;

  typedef enum logic [2:0] {
    CMP_EQ, CMP_NE, CMP_LT, CMP_GE, CMP_LTU, CMP_GEU
  } cmp_op_e;

  typedef enum logic [2:0] {
    KIND_ALU, KIND_BRANCH, KIND_JAL, KIND_JALR, KIND_NOP, KIND_ECALL, KIND_ILLEGAL
  } insn_kind_e;

  typedef struct packed {
    insn_kind_e kind;
    alu_op_e    alu_op;
    cmp_op_e    cmp_op;
    logic       a_is_pc;   // operand a is the pc, not rs1
    logic       b_is_imm;  // operand b is imm, not rs2
    reg_addr_t  rd;
    reg_addr_t  rs1;
    reg_addr_t  rs2;
    logic       rd_we;
    word_t      imm;
  } decoded_t;

  typedef struct packed {
    logic      valid;
    word_t     pc;
    reg_addr_t rd;
    logic      rd_we;
    word_t     wdata;
  } retire_t;

endpackage

`default_nettype wire

//--- hdl/fetch_ctrl.sv
`default_nettype none

module fetch_ctrl (
  input  logic              clk,
  input  logic              rst,
  output logic              fetch_req,
  output rv_pkg::word_t     fetch_pc,
  input  logic              fetch_ack,
  input  rv_pkg::insn_t     fetch_insn,
  output rv_pkg::insn_t     insn,
  output rv_pkg::word_t     pc,
  input  rv_pkg::decoded_t  dec,
  input  rv_pkg::word_t     alu_result,
  input  logic              branch_taken,
  output logic              wr_en,
  output rv_pkg::reg_addr_t wr_addr,
  output rv_pkg::word_t     wr_data,
  output rv_pkg::retire_t   retire,
  output logic              halt,
  output logic              illegal
);

  typedef enum logic [1:0] {
    S_REQ, S_WAIT_ACK_LOW, S_EXEC, S_HALTED
  } state_e;

  state_e        state;
  state_e        state_next;
  rv_pkg::word_t pc_plus4;
  rv_pkg::word_t pc_next;
  logic          is_jump;
  logic          stop;

  assign pc_plus4 = pc + 32'd4;
  assign is_jump  = dec.kind == rv_pkg::KIND_JAL || dec.kind == rv_pkg::KIND_JALR;
  assign stop     = dec.kind == rv_pkg::KIND_ECALL || dec.kind == rv_pkg::KIND_ILLEGAL;

  always_comb begin
    pc_next = pc_plus4;
    case (dec.kind)
      rv_pkg::KIND_BRANCH: if (branch_taken) pc_next = pc + dec.imm;
      rv_pkg::KIND_JAL:    pc_next = pc + dec.imm;
      rv_pkg::KIND_JALR:   pc_next = {alu_result[rv_pkg::XLEN-1:1], 1'b0};
      default: ;
    endcase
  end

  // four-phase fetch, then one execute cycle
  always_comb begin
    state_next = state;
    case (state)
      S_REQ:          if (fetch_req && fetch_ack) state_next = S_WAIT_ACK_LOW;
      S_WAIT_ACK_LOW: if (!fetch_ack) state_next = S_EXEC;
      S_EXEC:         state_next = stop ? S_HALTED : S_REQ;
      default: ;  // halted until reset
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= S_REQ;
      fetch_req <= 1'b0;  // first request one cycle after reset drops
      pc        <= rv_pkg::RESET_PC;
      illegal   <= 1'b0;
    end else begin
      state     <= state_next;
      fetch_req <= state_next == S_REQ;
      if (state == S_EXEC) begin
        pc      <= pc_next;
        illegal <= dec.kind == rv_pkg::KIND_ILLEGAL;
      end
    end
  end

  // instruction register, loaded on the ack edge
  always_ff @(posedge clk) begin
    if (state == S_REQ && fetch_req && fetch_ack) insn <= fetch_insn;
  end

  assign fetch_pc = pc;
  assign halt     = state == S_HALTED;

  assign wr_en   = state == S_EXEC && dec.rd_we;
  assign wr_addr = dec.rd;
  assign wr_data = is_jump ? pc_plus4 : alu_result;  // link address for jumps

  always_comb begin
    retire.valid = state == S_EXEC;
    retire.pc    = pc;
    retire.rd    = dec.rd;
    retire.rd_we = dec.rd_we;
    retire.wdata = wr_data;
  end

endmodule

`default_nettype wire

//--- hdl/rv_decode.sv
`default_nettype none

module rv_decode (
  input  rv_pkg::insn_t    insn,
  output rv_pkg::decoded_t dec
);

  rv_pkg::word_t imm_i;
  rv_pkg::word_t imm_b;
  rv_pkg::word_t imm_u;
  rv_pkg::word_t imm_j;
  logic          f7_zero;
  logic          f7_alt;   // sub / sra encoding

  assign imm_i = {{20{insn.i.imm_11_0[11]}}, insn.i.imm_11_0};
  assign imm_b = {{19{insn.b.imm_12}}, insn.b.imm_12, insn.b.imm_11,
                  insn.b.imm_10_5, insn.b.imm_4_1, 1'b0};
  assign imm_u = {insn.u.imm_31_12, 12'b0};
  assign imm_j = {{11{insn.j.imm_20}}, insn.j.imm_20, insn.j.imm_19_12,
                  insn.j.imm_11, insn.j.imm_10_1, 1'b0};

  assign f7_zero = insn.r.funct7 == 7'b0000000;
  assign f7_alt  = insn.r.funct7 == 7'b0100000;

  always_comb begin
    dec        = '0;
    dec.kind   = rv_pkg::KIND_ILLEGAL;
    dec.alu_op = rv_pkg::ALU_ADD;
    dec.cmp_op = rv_pkg::CMP_EQ;
    dec.rd     = insn.r.rd;
    dec.rs1    = insn.r.rs1;
    dec.rs2    = insn.r.rs2;
    dec.imm    = imm_i;
    case (insn.r.opcode)
      rv_pkg::OP_LUI: begin
        dec.kind     = rv_pkg::KIND_ALU;
        dec.alu_op   = rv_pkg::ALU_PASS_B;
        dec.b_is_imm = 1'b1;
        dec.imm      = imm_u;
      end
      rv_pkg::OP_AUIPC: begin
        dec.kind     = rv_pkg::KIND_ALU;
        dec.a_is_pc  = 1'b1;
        dec.b_is_imm = 1'b1;
        dec.imm      = imm_u;
      end
      rv_pkg::OP_JAL: begin
        dec.kind = rv_pkg::KIND_JAL;
        dec.imm  = imm_j;
      end
      rv_pkg::OP_JALR: begin
        dec.b_is_imm = 1'b1;  // target = rs1 + imm through the alu
        if (insn.i.funct3 == 3'b000) dec.kind = rv_pkg::KIND_JALR;
      end
      rv_pkg::OP_BRANCH: begin
        dec.kind = rv_pkg::KIND_BRANCH;
        dec.imm  = imm_b;
        case (insn.b.funct3)
          3'b000:  dec.cmp_op = rv_pkg::CMP_EQ;
          3'b001:  dec.cmp_op = rv_pkg::CMP_NE;
          3'b100:  dec.cmp_op = rv_pkg::CMP_LT;
          3'b101:  dec.cmp_op = rv_pkg::CMP_GE;
          3'b110:  dec.cmp_op = rv_pkg::CMP_LTU;
          3'b111:  dec.cmp_op = rv_pkg::CMP_GEU;
          default: dec.kind   = rv_pkg::KIND_ILLEGAL;
        endcase
      end
      rv_pkg::OP_REG_IMM, rv_pkg::OP_REG_REG: begin
        dec.kind     = rv_pkg::KIND_ALU;
        dec.b_is_imm = insn.r.opcode == rv_pkg::OP_REG_IMM;
        case (insn.r.funct3)
          3'b000:  dec.alu_op = (f7_alt && !dec.b_is_imm) ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
          3'b001:  dec.alu_op = rv_pkg::ALU_SLL;
          3'b010:  dec.alu_op = rv_pkg::ALU_SLT;
          3'b011:  dec.alu_op = rv_pkg::ALU_SLTU;
          3'b100:  dec.alu_op = rv_pkg::ALU_XOR;
          3'b101:  dec.alu_op = f7_alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
          3'b110:  dec.alu_op = rv_pkg::ALU_OR;
          default: dec.alu_op = rv_pkg::ALU_AND;
        endcase
        // funct7 only matters for shifts (imm form) or every reg form
        if ((!dec.b_is_imm || insn.r.funct3 == 3'b001 || insn.r.funct3 == 3'b101) &&
            !(f7_zero || (f7_alt && (insn.r.funct3 == 3'b101 ||
                                     (insn.r.funct3 == 3'b000 && !dec.b_is_imm)))))
          dec.kind = rv_pkg::KIND_ILLEGAL;
      end
      rv_pkg::OP_MISC_MEM: begin
        if (insn.i.funct3 == 3'b000) dec.kind = rv_pkg::KIND_NOP;  // fence
      end
      rv_pkg::OP_SYSTEM: begin
        if (insn.i.imm_11_0 == '0 && insn.i.rs1 == '0 && insn.i.funct3 == '0 &&
            insn.i.rd == '0)
          dec.kind = rv_pkg::KIND_ECALL;
      end
      default: ;
    endcase
    dec.rd_we = dec.kind == rv_pkg::KIND_ALU || dec.kind == rv_pkg::KIND_JAL ||
                dec.kind == rv_pkg::KIND_JALR;
  end

endmodule

`default_nettype wire

//--- hdl/reg_file.sv
`default_nettype none

module reg_file (
  input  logic              clk,
  input  logic              rst,
  input  rv_pkg::reg_addr_t rs1,
  input  rv_pkg::reg_addr_t rs2,
  output rv_pkg::word_t     rs1_data,
  output rv_pkg::word_t     rs2_data,
  input  logic              wr_en,
  input  rv_pkg::reg_addr_t wr_addr,
  input  rv_pkg::word_t     wr_data
);

  localparam int NUM_REGS = 2 ** rv_pkg::REG_ADDR_W;

  // x0 has no storage
  rv_pkg::word_t regs [1:NUM_REGS-1];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int k = 1; k < NUM_REGS; k++) begin
        regs[k] <= '0;
      end
    end else if (wr_en && wr_addr != '0) begin
      regs[wr_addr] <= wr_data;
    end
  end

  // reads are combinational, new value visible after the write edge
  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

//--- hdl/rv_alu.sv
`default_nettype none

module rv_alu (
  input  rv_pkg::decoded_t dec,
  input  rv_pkg::word_t    rs1_data,
  input  rv_pkg::word_t    rs2_data,
  input  rv_pkg::word_t    pc,
  output rv_pkg::word_t    alu_result,
  output logic             branch_taken
);

  rv_pkg::word_t op_a;
  rv_pkg::word_t op_b;
  logic [4:0]    shamt;

  assign op_a  = dec.a_is_pc ? pc : rs1_data;
  assign op_b  = dec.b_is_imm ? dec.imm : rs2_data;
  assign shamt = op_b[4:0];  // rv32 shifts use 5 bits only

  always_comb begin
    case (dec.alu_op)
      rv_pkg::ALU_ADD:    alu_result = op_a + op_b;
      rv_pkg::ALU_SUB:    alu_result = op_a - op_b;
      rv_pkg::ALU_SLL:    alu_result = op_a << shamt;
      rv_pkg::ALU_SLT:    alu_result = rv_pkg::word_t'($signed(op_a) < $signed(op_b));
      rv_pkg::ALU_SLTU:   alu_result = rv_pkg::word_t'(op_a < op_b);
      rv_pkg::ALU_XOR:    alu_result = op_a ^ op_b;
      rv_pkg::ALU_SRL:    alu_result = op_a >> shamt;
      rv_pkg::ALU_SRA:    alu_result = $signed(op_a) >>> shamt;
      rv_pkg::ALU_OR:     alu_result = op_a | op_b;
      rv_pkg::ALU_AND:    alu_result = op_a & op_b;
      rv_pkg::ALU_PASS_B: alu_result = op_b;  // lui
      default:            alu_result = '0;
    endcase
  end

  // branch compare always on the two registers
  always_comb begin
    case (dec.cmp_op)
      rv_pkg::CMP_EQ:  branch_taken = rs1_data == rs2_data;
      rv_pkg::CMP_NE:  branch_taken = rs1_data != rs2_data;
      rv_pkg::CMP_LT:  branch_taken = $signed(rs1_data) < $signed(rs2_data);
      rv_pkg::CMP_GE:  branch_taken = $signed(rs1_data) >= $signed(rs2_data);
      rv_pkg::CMP_LTU: branch_taken = rs1_data < rs2_data;
      rv_pkg::CMP_GEU: branch_taken = rs1_data >= rs2_data;
      default:         branch_taken = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

//--- hdl/rv_core.sv
`default_nettype none

module rv_core (
  input  logic             clk,
  input  logic             rst,
  output logic             fetch_req,
  output rv_pkg::word_t    fetch_pc,
  input  logic             fetch_ack,
  input  rv_pkg::insn_t    fetch_insn,
  output rv_pkg::retire_t  retire,
  output logic             halt,
  output logic             illegal
);

  rv_pkg::insn_t     insn;
  rv_pkg::word_t     pc;
  rv_pkg::decoded_t  dec;
  rv_pkg::word_t     rs1_data;
  rv_pkg::word_t     rs2_data;
  rv_pkg::word_t     alu_result;
  logic              branch_taken;
  logic              wr_en;
  rv_pkg::reg_addr_t wr_addr;
  rv_pkg::word_t     wr_data;

  fetch_ctrl fetch_ctrl_i (
    .clk          (clk),
    .rst          (rst),
    .fetch_req    (fetch_req),
    .fetch_pc     (fetch_pc),
    .fetch_ack    (fetch_ack),
    .fetch_insn   (fetch_insn),
    .insn         (insn),
    .pc           (pc),
    .dec          (dec),
    .alu_result   (alu_result),
    .branch_taken (branch_taken),
    .wr_en        (wr_en),
    .wr_addr      (wr_addr),
    .wr_data      (wr_data),
    .retire       (retire),
    .halt         (halt),
    .illegal      (illegal)
  );

  rv_decode rv_decode_i (
    .insn (insn),
    .dec  (dec)
  );

  reg_file reg_file_i (
    .clk      (clk),
    .rst      (rst),
    .rs1      (dec.rs1),
    .rs2      (dec.rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .wr_en    (wr_en),
    .wr_addr  (wr_addr),
    .wr_data  (wr_data)
  );

  rv_alu rv_alu_i (
    .dec          (dec),
    .rs1_data     (rs1_data),
    .rs2_data     (rs2_data),
    .pc           (pc),
    .alu_result   (alu_result),
    .branch_taken (branch_taken)
  );

endmodule

`default_nettype wire

//--- dv/tb_rv_core.sv
`default_nettype none

module tb_rv_core;

  timeunit 1ns;
  timeprecision 1ps;

  logic            clk;
  logic            rst;
  logic            fetch_req;
  rv_pkg::word_t   fetch_pc;
  logic            fetch_ack;
  rv_pkg::insn_t   fetch_insn;
  rv_pkg::retire_t retire;
  logic            halt;
  logic            illegal;

  logic [31:0] mem [2][64];  // one instruction memory per program
  logic [31:0] e_pc[$];
  logic [31:0] e_rd[$];
  logic [31:0] e_we[$];
  logic [31:0] e_wd[$];
  int          exp_end [2];
  logic [31:0] exp_ill [2];
  int          np;
  int          cur;
  int          e_idx;
  int          errors;
  int          limit_cycles;
  logic        loaded;
  logic        first_req;
  logic        req_q;
  logic        ack_q;
  rv_pkg::word_t pc_q;
  logic [31:0] lfsr;
  int          fd;
  string       line;
  logic [31:0] f_a;
  logic [31:0] f_b;
  logic [31:0] f_c;
  logic [31:0] f_d;
  int          code;
  int          delay;

  rv_core rv_core_i (
    .clk        (clk),
    .rst        (rst),
    .fetch_req  (fetch_req),
    .fetch_pc   (fetch_pc),
    .fetch_ack  (fetch_ack),
    .fetch_insn (fetch_insn),
    .retire     (retire),
    .halt       (halt),
    .illegal    (illegal)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // galois lfsr, one step per random bit
  function automatic logic lfsr_bit();
    logic lsb;
    lsb  = lfsr[0];
    lfsr = lfsr >> 1;
    if (lsb) lfsr = lfsr ^ 32'h8020_0003;
    return lsb;
  endfunction

  function automatic int rand_delay();
    logic b1;
    logic b0;
    b1 = lfsr_bit();
    b0 = lfsr_bit();
    return int'({b1, b0});
  endfunction

  // instruction memory side of the four-phase port
  initial begin
    fetch_ack  = 1'b0;
    fetch_insn = '0;
    forever begin
      @(negedge clk);
      if (!rst && fetch_req && !fetch_ack) begin
        delay = rand_delay();
        repeat (delay) @(negedge clk);
        fetch_insn = mem[cur][fetch_pc[7:2]];
        fetch_ack  = 1'b1;
        do @(negedge clk); while (fetch_req);
        delay = rand_delay();
        repeat (delay) @(negedge clk);
        fetch_ack = 1'b0;
      end
    end
  end

  // handshake rules and retire trace, sampled before the edge updates
  always @(posedge clk) begin
    if (rst) begin
      req_q = 1'b0;
      ack_q = 1'b0;
    end else begin
      if (fetch_req && !req_q && ack_q) begin
        errors++;
        $display("fetch_req rose while fetch_ack was still high");
      end
      if (fetch_req && req_q && fetch_pc !== pc_q) begin
        errors++;
        $display("fetch_pc changed while fetch_req was high");
      end
      if (fetch_req && !req_q && first_req) begin
        first_req = 1'b0;
        if (fetch_pc !== rv_pkg::RESET_PC) begin
          errors++;
          $display("[ERROR] fetch_pc first request: got 0x%08h, expected 0x%08h",
                   fetch_pc, rv_pkg::RESET_PC);
        end
      end
      if (retire.valid) begin
        if (e_idx >= exp_end[cur]) begin
          errors++;
          $display("retire at pc 0x%08h was not expected", retire.pc);
        end else begin
          if (retire.pc !== e_pc[e_idx]) begin
            errors++;
            $display("[ERROR] retire.pc: got 0x%08h, expected 0x%08h", retire.pc, e_pc[e_idx]);
          end
          if (retire.rd_we !== e_we[e_idx][0]) begin
            errors++;
            $display("[ERROR] retire.rd_we at pc 0x%08h: got 0x%0h, expected 0x%0h",
                     retire.pc, retire.rd_we, e_we[e_idx][0]);
          end
          if (e_we[e_idx][0] && retire.rd !== e_rd[e_idx][4:0]) begin
            errors++;
            $display("[ERROR] retire.rd at pc 0x%08h: got 0x%02h, expected 0x%02h",
                     retire.pc, retire.rd, e_rd[e_idx][4:0]);
          end
          if (e_we[e_idx][0] && retire.wdata !== e_wd[e_idx]) begin
            errors++;
            $display("[ERROR] retire.wdata at pc 0x%08h: got 0x%08h, expected 0x%08h",
                     retire.pc, retire.wdata, e_wd[e_idx]);
          end
          e_idx++;
        end
      end
      req_q = fetch_req;
      ack_q = fetch_ack;
      pc_q  = fetch_pc;
    end
  end

  initial begin
    wait (loaded);
    #(limit_cycles * 4);
    $display("watchdog expired after %0d cycles, the core stopped making progress",
             limit_cycles);
    $display("SIMULATION FAILED");
    $finish;
  end

  initial begin
    rst       = 1'b1;
    cur       = 0;
    e_idx     = 0;
    errors    = 0;
    np        = 0;
    loaded    = 1'b0;
    first_req = 1'b0;
    lfsr      = 32'he7ee_aa21;
    for (int p = 0; p < 2; p++) begin
      for (int k = 0; k < 64; k++) begin
        mem[p][k] = (p << 14) | (k << 8);  // opcode 0 everywhere, so stray fetches are illegal
      end
    end
    fd = $fopen("dv/rv_cases.txt", "r");
    if (fd == 0) begin
      $display("could not open dv/rv_cases.txt");
    end else begin
      while (!$feof(fd) && np < 2) begin
        code = $fgets(line, fd);
        if (line.len() > 1) begin
          case (line[0])
            "p": begin
              code = $sscanf(line, "p %h %h", f_a, f_b);
              mem[np][f_a[7:2]] = f_b;
            end
            "e": begin
              code = $sscanf(line, "e %h %h %h %h", f_a, f_b, f_c, f_d);
              e_pc.push_back(f_a);
              e_rd.push_back(f_b);
              e_we.push_back(f_c);
              e_wd.push_back(f_d);
            end
            "h": begin
              code = $sscanf(line, "h %h", f_a);
              exp_ill[np] = f_a;
              exp_end[np] = e_pc.size();
              np++;
            end
            default: ;
          endcase
        end
      end
      $fclose(fd);
    end
    if (np != 2) begin
      errors++;
      $display("case file did not hold two complete programs");
    end else begin
      limit_cycles = (exp_end[0] + 4) * 12 + (exp_end[1] - exp_end[0] + 4) * 12;
      loaded = 1'b1;
      for (int p = 0; p < 2; p++) begin
        rst   = 1'b1;
        cur   = p;
        e_idx = (p == 0) ? 0 : exp_end[0];
        repeat (3) begin
          @(negedge clk);
          if (fetch_req !== 1'b0 || retire.valid !== 1'b0 || halt !== 1'b0 ||
              illegal !== 1'b0) begin
            errors++;
            $display("[ERROR] reset outputs of program %0d: fetch_req=0x%0h",
                     p, fetch_req);
            $display("[ERROR]   retire.valid=0x%0h halt=0x%0h illegal=0x%0h, expected 0x0",
                     retire.valid, halt, illegal);
          end
        end
        first_req = 1'b1;
        rst       = 1'b0;
        while (halt !== 1'b1) @(negedge clk);
        if (illegal !== exp_ill[p][0]) begin
          errors++;
          $display("[ERROR] illegal after halt: got 0x%0h, expected 0x%0h",
                   illegal, exp_ill[p][0]);
        end
        if (e_idx != exp_end[p]) begin
          errors++;
          $display("program %0d halted with %0d retires missing", p, exp_end[p] - e_idx);
        end
        repeat (20) begin
          @(negedge clk);
          if (fetch_req || !halt) begin
            errors++;
            $display("core left the halted state or fetched again in program %0d", p);
          end
        end
      end
    end
    $display("checks done, %0d errors", errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- dv/rv_cases.txt
# p <addr> <insn> | e <pc> <rd> <rd_we> <wdata> | h <illegal>
# program one: alu, lui, auipc, fence, branches, jumps, ecall
p 00 800000B7
p 04 FFF00113
p 08 00500193
p 0C 0010A213
p 10 0010B293
p 14 00312333
p 18 003133B3
p 1C 00009413
p 20 41F0D493
p 24 01F0D513
p 28 00A195B3
p 2C 40A18633
p 30 4030D6B3
p 34 0030D733
p 38 003147B3
p 3C 0030E833
p 40 003178B3
p 44 7FF1C913
p 48 0101E993
p 4C 0F017A13
p 50 00208AB3
p 54 00718013
p 58 00300B33
p 5C 00001B97
p 60 0FF0000F
p 64 01618463
p 68 00100C13
p 6C 01619463
p 70 0030C463
p 74 00100C13
p 78 0030D463
p 7C 0030E463
p 80 0030F463
p 84 00100C13
p 88 0011D463
p 8C 00100C13
p 90 0011E463
p 94 00100C13
p 98 00118463
p 9C 0011C463
p A0 00119463
p A4 00100C13
p A8 0011F463
p AC 00C00CEF
p B0 00100C13
p B4 00100C13
p B8 015C8D67
p BC 00100C13
p C0 00100C13
p C4 00000073
e 00 01 1 80000000
e 04 02 1 FFFFFFFF
e 08 03 1 00000005
e 0C 04 1 00000001
e 10 05 1 00000000
e 14 06 1 00000001
e 18 07 1 00000000
e 1C 08 1 80000000
e 20 09 1 FFFFFFFF
e 24 0A 1 00000001
e 28 0B 1 0000000A
e 2C 0C 1 00000004
e 30 0D 1 FC000000
e 34 0E 1 04000000
e 38 0F 1 FFFFFFFA
e 3C 10 1 80000005
e 40 11 1 00000005
e 44 12 1 000007FA
e 48 13 1 00000015
e 4C 14 1 000000F0
e 50 15 1 7FFFFFFF
e 54 00 1 0000000C
e 58 16 1 00000005
e 5C 17 1 0000105C
e 60 00 0 00000000
e 64 00 0 00000000
e 6C 00 0 00000000
e 70 00 0 00000000
e 78 00 0 00000000
e 7C 00 0 00000000
e 80 00 0 00000000
e 88 00 0 00000000
e 90 00 0 00000000
e 98 00 0 00000000
e 9C 00 0 00000000
e A0 00 0 00000000
e A8 00 0 00000000
e AC 19 1 000000B0
e B8 1A 1 000000BC
e C4 00 0 00000000
h 0
# program two: two alu ops, then an unsupported opcode
p 00 12300093
p 04 FFD08113
p 08 0000007F
e 00 01 1 00000123
e 04 02 1 00000120
e 08 00 0 00000000
h 1

//--- verilog.f
common/rv_pkg.sv
hdl/fetch_ctrl.sv
hdl/rv_decode.sv
hdl/reg_file.sv
hdl/rv_alu.sv
hdl/rv_core.sv
dv/tb_rv_core.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the rv_core testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal \
  --top-module tb_rv_core \
  -f verilog.f

./obj_dir/Vtb_rv_core | tee sim.log

if grep -q "SIMULATION PASSED" sim.log; then
  exit 0
else
  exit 1
fi
